// ==== rtl/issue_pkg.sv ====
// shared definitions for the rv32i issue pipeline
// register geometry, pipe depth, opcode and funct encodings, alu ops
// and the instruction word union used by decode and the testbench

package issue_pkg;

    ////////////////////
    // geometry
    localparam int XLEN        = 32;
    localparam int REG_ADDR_W  = 5;
    localparam int NUM_REGS    = 32;

    // execution pipe depth, wb lands EXEC_STAGES cycles after bus valid
    localparam int EXEC_STAGES = 3;

    // one sweep cycle per register after reset
    localparam int INIT_CYCLES = NUM_REGS;
    localparam int INIT_CNT_W  = $clog2(INIT_CYCLES + 1);

    ////////////////////
    // encodings
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

    localparam logic [2:0] F3_ADD = 3'b000;
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_OR  = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;

    // funct7 marking sub, plain r-type ops use all zero
    localparam logic [6:0] F7_SUB = 7'b0100000;

    typedef enum logic [2:0] {
        op_add,
        op_sub,
        op_xor,
        op_or,
        op_and
    } alu_op_t;

    // one instruction word, read as r-type or i-type
    typedef union packed {
        struct packed {
            logic [6:0]            funct7;
            logic [REG_ADDR_W-1:0] rs2;
            logic [REG_ADDR_W-1:0] rs1;
            logic [2:0]            funct3;
            logic [REG_ADDR_W-1:0] rd;
            logic [6:0]            opcode;
        } r_fields;
        struct packed {
            logic [11:0]           imm;
            logic [REG_ADDR_W-1:0] rs1;
            logic [2:0]            funct3;
            logic [REG_ADDR_W-1:0] rd;
            logic [6:0]            opcode;
        } i_fields;
    } instr_t;

endpackage

// ==== rtl/issue_bus_if.sv ====
// issued instruction from decode_issue to alu_pipe
// valid is a one-cycle strobe, no back-pressure since the pipe always accepts
// payload is only meaningful while valid is high

`timescale 1ns/10ps

interface issue_bus_if
    import issue_pkg::*;
();

    logic                  valid;
    logic [REG_ADDR_W-1:0] rd;
    alu_op_t               op;
    // operand a is rs1, b is rs2 or the extended immediate
    logic [XLEN-1:0]       a;
    logic [XLEN-1:0]       b;

    // issue side drives everything
    modport issue (
        output valid, rd, op, a, b
    );

    // exec side only listens
    modport exec (
        input valid, rd, op, a, b
    );

endinterface

// ==== rtl/reg_inuse.sv ====
// register in-use scoreboard built from two toggle banks
// issue flips bank a, completion or the clear sweep copies a into b
// a register is busy while the two banks differ; clr must be held
// for a full sweep after reset before the lookups are trusted

`timescale 1ns/10ps

module reg_inuse
    import issue_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  clr,
    input  logic [REG_ADDR_W-1:0] rs1_addr,
    input  logic [REG_ADDR_W-1:0] rs2_addr,
    input  logic [REG_ADDR_W-1:0] rd_check_addr,
    input  logic [REG_ADDR_W-1:0] issue_addr,
    input  logic [REG_ADDR_W-1:0] completed_addr,
    input  logic                  issued,
    input  logic                  completed,
    output logic                  rs1_inuse,
    output logic                  rs2_inuse,
    output logic                  rd_inuse
);

    // one bit per register in each bank
    logic bank_a [NUM_REGS];
    logic bank_b [NUM_REGS];

    logic [REG_ADDR_W-1:0] clr_addr;
    logic [REG_ADDR_W-1:0] done_addr;
    logic                  collision;

    ////////////////////
    // clear sweep

    // walks every register once while clr is up
    always_ff @(posedge clk) begin
        if (rst) begin
            clr_addr <= '0;
        end else if (clr) begin
            clr_addr <= clr_addr + 1'b1;
        end
    end

    // sweep borrows the completion write port
    assign done_addr = clr ? clr_addr : completed_addr;

    ////////////////////
    // bank updates

    // issue and completion hitting the same register this cycle
    assign collision = completed && (issue_addr == completed_addr);

    // on a collision b takes the old a value, so flip a against that
    // and the register stays busy, issue wins
    always_ff @(posedge clk) begin
        if (issued) begin
            bank_a[issue_addr] <= collision ? ~bank_a[completed_addr] : ~bank_b[issue_addr];
        end
    end

    // completion brings b back in line with a
    always_ff @(posedge clk) begin
        if (completed || clr) begin
            bank_b[done_addr] <= bank_a[done_addr];
        end
    end

    ////////////////////
    // lookups

    // busy while banks disagree
    assign rs1_inuse = bank_a[rs1_addr] ^ bank_b[rs1_addr];
    assign rs2_inuse = bank_a[rs2_addr] ^ bank_b[rs2_addr];
    assign rd_inuse  = bank_a[rd_check_addr] ^ bank_b[rd_check_addr];

endmodule

// ==== rtl/reg_file.sv ====
// integer register file, 32 entries of XLEN bits
// two combinational read ports and one write port from writeback
// x0 ignores writes and always reads zero

`timescale 1ns/10ps

module reg_file
    import issue_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic [REG_ADDR_W-1:0] rs1_addr,
    input  logic [REG_ADDR_W-1:0] rs2_addr,
    input  logic                  we,
    input  logic [REG_ADDR_W-1:0] wr_addr,
    input  logic [XLEN-1:0]       wr_data,
    output logic [XLEN-1:0]       rs1_data,
    output logic [XLEN-1:0]       rs2_data
);

    logic [XLEN-1:0] regs [NUM_REGS];

    // flop array, all zero out of reset
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (wr_addr != '0)) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // no write bypass, a same-cycle write shows up next cycle
    // the scoreboard keeps readers off the register until then
    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

// ==== rtl/decode_issue.sv ====
// decode and issue stage
// decodes the offered word, reads operands, checks the scoreboard and
// either stalls or accepts; legal ops with a nonzero rd go out on the bus
// one cycle later, everything else accepted is simply dropped

`timescale 1ns/10ps

module decode_issue
    import issue_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  instr_valid,
    input  instr_t                instr,
    input  logic                  rs1_inuse,
    input  logic                  rs2_inuse,
    input  logic                  rd_inuse,
    input  logic [XLEN-1:0]       rs1_data,
    input  logic [XLEN-1:0]       rs2_data,
    output logic                  stall,
    output logic                  clr,
    output logic [REG_ADDR_W-1:0] rs1_addr,
    output logic [REG_ADDR_W-1:0] rs2_addr,
    output logic [REG_ADDR_W-1:0] rd_check_addr,
    output logic                  issued,
    output logic [REG_ADDR_W-1:0] issue_addr,
    issue_bus_if.issue            bus
);

    logic                  is_r;
    logic                  is_i;
    logic                  f3_ok;
    logic                  legal;
    logic                  hazard;
    logic                  accept;
    logic                  init_busy;
    logic [INIT_CNT_W-1:0] init_cnt;
    logic [REG_ADDR_W-1:0] rd;
    alu_op_t               op;
    logic [XLEN-1:0]       operand_b;

    ////////////////////
    // init sweep

    // counts up to INIT_CYCLES once after reset, then parks
    always_ff @(posedge clk) begin
        if (rst) begin
            init_cnt <= '0;
        end else if (init_busy) begin
            init_cnt <= init_cnt + 1'b1;
        end
    end

    assign init_busy = (init_cnt != INIT_CNT_W'(INIT_CYCLES));
    assign clr       = init_busy;

    ////////////////////
    // decode

    assign is_r = (instr.r_fields.opcode == OPC_OP);
    assign is_i = (instr.i_fields.opcode == OPC_OP_IMM);

    // only add, xor, or, and in funct3 space
    assign f3_ok = (instr.r_fields.funct3 == F3_ADD) || (instr.r_fields.funct3 == F3_XOR) ||
                   (instr.r_fields.funct3 == F3_OR)  || (instr.r_fields.funct3 == F3_AND);

    // r-type needs a clean funct7, sub only pairs with the add funct3
    assign legal = f3_ok && (is_i || (is_r && ((instr.r_fields.funct7 == 7'd0) ||
                   ((instr.r_fields.funct7 == F7_SUB) && (instr.r_fields.funct3 == F3_ADD)))));

    always_comb begin
        case (instr.r_fields.funct3)
            F3_XOR:  op = op_xor;
            F3_OR:   op = op_or;
            F3_AND:  op = op_and;
            default: op = (is_r && (instr.r_fields.funct7 == F7_SUB)) ? op_sub : op_add;
        endcase
    end

    // rd sits at the same bits in both views
    assign rd = instr.r_fields.rd;

    // second operand, rs2 for r-type, sign extended imm otherwise
    assign operand_b = is_r ? rs2_data
                            : {{(XLEN - 12){instr.i_fields.imm[11]}}, instr.i_fields.imm};

    ////////////////////
    // hazards and handshake

    assign rs1_addr      = instr.r_fields.rs1;
    assign rs2_addr      = instr.r_fields.rs2;
    assign rd_check_addr = rd;

    // rs2 field is immediate bits for i-type, so skip it there
    assign hazard = legal && (rs1_inuse || (is_r && rs2_inuse) || rd_inuse);

    assign stall  = init_busy || (instr_valid && hazard);
    assign accept = instr_valid && !stall;

    assign issued     = accept && legal && (rd != '0);
    assign issue_addr = rd;

    // bus strobe, cleared by reset
    always_ff @(posedge clk) begin
        if (rst) begin
            bus.valid <= 1'b0;
        end else begin
            bus.valid <= issued;
        end
    end

    // payload only moves on an issue
    always_ff @(posedge clk) begin
        if (issued) begin
            bus.rd <= rd;
            bus.op <= op;
            bus.a  <= rs1_data;
            bus.b  <= operand_b;
        end
    end

endmodule

// ==== rtl/alu_pipe.sv ====
// fixed depth execution pipe
// result is computed from the bus in the first stage and then carried
// through EXEC_STAGES registers; the last stage is the writeback strobe
// several instructions may be in flight, always in issue order

`timescale 1ns/10ps

module alu_pipe
    import issue_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    issue_bus_if.exec             bus,
    output logic                  wb_valid,
    output logic [REG_ADDR_W-1:0] wb_rd,
    output logic [XLEN-1:0]       wb_data
);

    logic [XLEN-1:0]        result;
    // stage 0 is the first register after the bus
    logic [EXEC_STAGES-1:0] valid_q;
    logic [REG_ADDR_W-1:0]  rd_q   [EXEC_STAGES];
    logic [XLEN-1:0]        data_q [EXEC_STAGES];

    ////////////////////
    // alu

    always_comb begin
        case (bus.op)
            op_sub:  result = bus.a - bus.b;
            op_xor:  result = bus.a ^ bus.b;
            op_or:   result = bus.a | bus.b;
            op_and:  result = bus.a & bus.b;
            default: result = bus.a + bus.b;
        endcase
    end

    ////////////////////
    // stage registers

    // valid chain, shifts in the bus strobe
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
        end else begin
            valid_q <= {valid_q[EXEC_STAGES-2:0], bus.valid};
        end
    end

    // rd and data just follow along
    always_ff @(posedge clk) begin
        rd_q[0]   <= bus.rd;
        data_q[0] <= result;
        for (int s = 1; s < EXEC_STAGES; s++) begin
            rd_q[s]   <= rd_q[s-1];
            data_q[s] <= data_q[s-1];
        end
    end

    // writeback out of the last stage
    assign wb_valid = valid_q[EXEC_STAGES-1];
    assign wb_rd    = rd_q[EXEC_STAGES-1];
    assign wb_data  = data_q[EXEC_STAGES-1];

endmodule

// ==== rtl/issue_pipeline_top.sv ====
// top of the issue pipeline, instances and wiring only
// the source holds instr_valid and instr while stall is high
// writeback is exposed for the checker

`timescale 1ns/10ps

module issue_pipeline_top
    import issue_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  instr_valid,
    input  logic [XLEN-1:0]       instr,
    output logic                  stall,
    output logic                  wb_valid,
    output logic [REG_ADDR_W-1:0] wb_rd,
    output logic [XLEN-1:0]       wb_data
);

    // decode to scoreboard and register file
    logic                  clr;
    logic                  issued;
    logic [REG_ADDR_W-1:0] rs1_addr;
    logic [REG_ADDR_W-1:0] rs2_addr;
    logic [REG_ADDR_W-1:0] rd_check_addr;
    logic [REG_ADDR_W-1:0] issue_addr;
    logic                  rs1_inuse;
    logic                  rs2_inuse;
    logic                  rd_inuse;
    logic [XLEN-1:0]       rs1_data;
    logic [XLEN-1:0]       rs2_data;

    issue_bus_if bus ();

    decode_issue u_decode_issue (
        .clk           (clk),
        .rst           (rst),
        .instr_valid   (instr_valid),
        .instr         (instr),
        .rs1_inuse     (rs1_inuse),
        .rs2_inuse     (rs2_inuse),
        .rd_inuse      (rd_inuse),
        .rs1_data      (rs1_data),
        .rs2_data      (rs2_data),
        .stall         (stall),
        .clr           (clr),
        .rs1_addr      (rs1_addr),
        .rs2_addr      (rs2_addr),
        .rd_check_addr (rd_check_addr),
        .issued        (issued),
        .issue_addr    (issue_addr),
        .bus           (bus.issue)
    );

    // writeback doubles as the completion port
    reg_inuse u_reg_inuse (
        .clk            (clk),
        .rst            (rst),
        .clr            (clr),
        .rs1_addr       (rs1_addr),
        .rs2_addr       (rs2_addr),
        .rd_check_addr  (rd_check_addr),
        .issue_addr     (issue_addr),
        .completed_addr (wb_rd),
        .issued         (issued),
        .completed      (wb_valid),
        .rs1_inuse      (rs1_inuse),
        .rs2_inuse      (rs2_inuse),
        .rd_inuse       (rd_inuse)
    );

    reg_file u_reg_file (
        .clk      (clk),
        .rst      (rst),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .we       (wb_valid),
        .wr_addr  (wb_rd),
        .wr_data  (wb_data),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    alu_pipe u_alu_pipe (
        .clk      (clk),
        .rst      (rst),
        .bus      (bus.exec),
        .wb_valid (wb_valid),
        .wb_rd    (wb_rd),
        .wb_data  (wb_data)
    );

endmodule

// ==== verif/issue_pipeline_properties.sv ====
// issue and scoreboard assertions for the issue pipeline
// bound into reg_inuse where issue, the clear sweep and completion all meet

`timescale 1ns/10ps

module issue_pipeline_properties (
    input logic clk,
    input logic rst,
    input logic stall,
    input logic issued,
    input logic issue_busy,
    input logic completed,
    input logic done_busy
);

    // a held instruction never goes out
    issue_while_stalled: assert property (@(posedge clk) disable iff (rst)
        issued |-> !stall)
        else $error("issued strobe while stall is high");

    // destination must be free when it is claimed
    issue_of_busy_reg: assert property (@(posedge clk) disable iff (rst)
        issued |-> !issue_busy)
        else $error("issue to a register that is already in use");

    // banks still differ right before the completing edge
    complete_of_idle_reg: assert property (@(posedge clk) disable iff (rst)
        completed |-> done_busy)
        else $error("completion of a register that was not in use");

endmodule

// nothing may issue during the clear sweep
bind reg_inuse issue_pipeline_properties u_inuse_props (
    .clk        (clk),
    .rst        (rst),
    .stall      (clr),
    .issued     (issued),
    .issue_busy (bank_a[issue_addr] ^ bank_b[issue_addr]),
    .completed  (completed),
    .done_busy  (bank_a[completed_addr] ^ bank_b[completed_addr])
);

// ==== verif/issue_pipeline_tb.sv ====
// testbench for the rv32i issue pipeline
// drives a seeded random alu stream, keeps an architectural model and checks
// every writeback for register, value, order and latency
// run through all.f with issue_pipeline_tb as the top module

`timescale 1ns/10ps

module issue_pipeline_tb
    import issue_pkg::*;
();

    localparam int N_INSTR        = 176;
    localparam int WB_LATENCY     = EXEC_STAGES + 1;
    localparam int TIMEOUT_CYCLES = INIT_CYCLES + 8 + 6 * N_INSTR + 50;

    logic                  clk;
    logic                  rst;
    logic                  instr_valid;
    instr_t                instr;
    logic                  stall;
    logic                  wb_valid;
    logic [REG_ADDR_W-1:0] wb_rd;
    logic [XLEN-1:0]       wb_data;

    int    seed = 4;
    int    cycle = 0;
    int    errors = 0;
    int    errs_before = 0;
    int    tests_run = 0;
    int    tests_failed = 0;
    string cur_test = "reset";

    // architectural state and writebacks still owed
    logic [XLEN-1:0]       model_regs [NUM_REGS];
    int                    last_write [NUM_REGS];
    logic [REG_ADDR_W-1:0] exp_rd [$];
    logic [XLEN-1:0]       exp_data [$];
    int                    exp_at [$];
    logic [2:0]            f3_list [4];

    issue_pipeline_top uut (
        .clk         (clk),
        .rst         (rst),
        .instr_valid (instr_valid),
        .instr       (instr),
        .stall       (stall),
        .wb_valid    (wb_valid),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // watchdog
    initial begin
        wait (cycle >= TIMEOUT_CYCLES);
        $display("timeout: stream still running after %0d cycles", cycle);
        $display("sim failed");
        $finish;
    end

    ////////////////////
    // instruction builders

    function automatic logic [31:0] rnd();
        return $random(seed);
    endfunction

    function automatic logic [REG_ADDR_W-1:0] pick_reg(input int base, input int span);
        return REG_ADDR_W'(base + int'(rnd() % span));
    endfunction

    function automatic instr_t make_r(input logic [6:0] f7, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3,
                                      input logic [4:0] rd);
        instr_t w;
        w.r_fields.funct7 = f7;
        w.r_fields.rs2    = rs2;
        w.r_fields.rs1    = rs1;
        w.r_fields.funct3 = f3;
        w.r_fields.rd     = rd;
        w.r_fields.opcode = OPC_OP;
        return w;
    endfunction

    function automatic instr_t make_i(input logic [11:0] imm, input logic [4:0] rs1,
                                      input logic [2:0] f3, input logic [4:0] rd);
        instr_t w;
        w.i_fields.imm    = imm;
        w.i_fields.rs1    = rs1;
        w.i_fields.funct3 = f3;
        w.i_fields.rd     = rd;
        w.i_fields.opcode = OPC_OP_IMM;
        return w;
    endfunction

    // random op, sub only rides on the add funct3
    function automatic instr_t make_rand_r(input logic [4:0] rs2, input logic [4:0] rs1,
                                           input logic [4:0] rd);
        logic [31:0] r;
        logic [2:0]  f3;
        r  = rnd();
        f3 = f3_list[r[1:0]];
        return make_r((r[2] && (f3 == F3_ADD)) ? F7_SUB : 7'd0, rs2, rs1, f3, rd);
    endfunction

    function automatic instr_t make_rand_i(input logic [4:0] rs1, input logic [4:0] rd);
        logic [31:0] r;
        r = rnd();
        return make_i(r[31:20], rs1, f3_list[r[1:0]], rd);
    endfunction

    function automatic instr_t illegal_word();
        instr_t w;
        w = rnd();
        // steer off the two opcodes of the subset
        if ((w.r_fields.opcode == OPC_OP) || (w.r_fields.opcode == OPC_OP_IMM)) begin
            w.r_fields.opcode[0] = ~w.r_fields.opcode[0];
        end
        return w;
    endfunction

    ////////////////////
    // model and checks

    // add, sub, xor, or, and plus the four immediates, nothing else
    function automatic bit is_legal(input instr_t w);
        bit f3_ok;
        f3_ok = (w.r_fields.funct3 == F3_ADD) || (w.r_fields.funct3 == F3_XOR) ||
                (w.r_fields.funct3 == F3_OR)  || (w.r_fields.funct3 == F3_AND);
        if (w.i_fields.opcode == OPC_OP_IMM) begin
            return f3_ok;
        end
        if (w.r_fields.opcode != OPC_OP) begin
            return 1'b0;
        end
        if (w.r_fields.funct7 == 7'd0) begin
            return f3_ok;
        end
        return (w.r_fields.funct7 == F7_SUB) && (w.r_fields.funct3 == F3_ADD);
    endfunction

    // no forwarding, so a reader waits for the producer's writeback
    task automatic check_gap(input logic [REG_ADDR_W-1:0] rs, input int at);
        if ((rs != '0) && (at - last_write[rs] < WB_LATENCY + 1)) begin
            $display("FAIL %s: x%0d accepted early, expected gap >= %0d actual %0d",
                     cur_test, rs, WB_LATENCY + 1, at - last_write[rs]);
            errors++;
        end
    endtask

    task automatic apply_instr(input int at);
        instr_t                w;
        logic                  is_r;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       a;
        logic [XLEN-1:0]       b;
        logic [XLEN-1:0]       res;
        w = instr;
        if (is_legal(w)) begin
            is_r = (w.r_fields.opcode == OPC_OP);
            rd   = w.r_fields.rd;
            check_gap(w.r_fields.rs1, at);
            if (is_r) begin
                check_gap(w.r_fields.rs2, at);
            end
            check_gap(rd, at);
            a = model_regs[w.r_fields.rs1];
            b = is_r ? model_regs[w.r_fields.rs2]
                     : {{(XLEN - 12){w.i_fields.imm[11]}}, w.i_fields.imm};
            case (w.r_fields.funct3)
                F3_XOR:  res = a ^ b;
                F3_OR:   res = a | b;
                F3_AND:  res = a & b;
                default: res = (is_r && (w.r_fields.funct7 == F7_SUB)) ? a - b : a + b;
            endcase
            // x0 stays zero in the model too
            if (rd != '0) begin
                model_regs[rd] = res;
                last_write[rd] = at;
                exp_rd.push_back(rd);
                exp_data.push_back(res);
                exp_at.push_back(at);
            end
        end
    endtask

    task automatic check_wb(input int at);
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       data;
        int                    acc;
        if (exp_rd.size() == 0) begin
            $display("FAIL %s: writeback to x%0d with nothing outstanding", cur_test, wb_rd);
            errors++;
        end else begin
            rd   = exp_rd.pop_front();
            data = exp_data.pop_front();
            acc  = exp_at.pop_front();
            if (wb_rd != rd) begin
                $display("FAIL %s: wb_rd expected x%0d actual x%0d", cur_test, rd, wb_rd);
                errors++;
            end
            if (wb_data != data) begin
                $display("FAIL %s: wb_data expected %h actual %h", cur_test, data, wb_data);
                errors++;
            end
            if (at - acc != WB_LATENCY) begin
                $display("FAIL %s: wb latency expected %0d actual %0d",
                         cur_test, WB_LATENCY, at - acc);
                errors++;
            end
        end
    endtask

    // sampled mid cycle, credited to the edge that closes the cycle
    always @(negedge clk) begin
        if (!rst) begin
            if (instr_valid && !stall) begin
                apply_instr(cycle + 1);
            end
            if (wb_valid) begin
                check_wb(cycle + 1);
            end
        end
    end

    ////////////////////
    // stimulus

    // offer one word and hold it through any stall
    task automatic send(input instr_t w);
        instr_valid = 1'b1;
        instr       = w;
        @(negedge clk);
        while (stall) begin
            @(negedge clk);
        end
        @(posedge clk);
        #1;
    endtask

    // latency is fixed, so everything owed has landed after a few cycles
    task automatic settle();
        instr_valid = 1'b0;
        repeat (WB_LATENCY + 2) @(posedge clk);
        #1;
        if (exp_rd.size() != 0) begin
            $display("FAIL %s: %0d writebacks never arrived", cur_test, exp_rd.size());
            errors++;
            exp_rd.delete();
            exp_data.delete();
            exp_at.delete();
        end
    endtask

    task automatic begin_test(input string name);
        cur_test    = name;
        errs_before = errors;
    endtask

    task automatic close_test();
        tests_run++;
        if (errors == errs_before) begin
            $display("test %s: ok", cur_test);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", cur_test, errors - errs_before);
        end
    endtask

    initial begin
        logic [31:0]           r;
        logic [REG_ADDR_W-1:0] ra;
        logic [REG_ADDR_W-1:0] rb;
        logic [REG_ADDR_W-1:0] rc;
        logic [REG_ADDR_W-1:0] prev;
        int                    init_len;
        f3_list = '{F3_ADD, F3_XOR, F3_OR, F3_AND};
        for (int i = 0; i < NUM_REGS; i++) begin
            model_regs[i] = '0;
            last_write[i] = -100;
        end
        rst         = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;

        // scoreboard sweep holds stall
        begin_test("init");
        init_len = 0;
        @(negedge clk);
        while (stall && (init_len <= 2 * INIT_CYCLES)) begin
            if (wb_valid) begin
                $display("FAIL init: writeback seen during the init sweep");
                errors++;
            end
            init_len++;
            @(negedge clk);
        end
        if (init_len != INIT_CYCLES) begin
            $display("FAIL init: stall cycles expected %0d actual %0d", INIT_CYCLES, init_len);
            errors++;
        end
        @(posedge clk);
        #1;
        close_test();

        // seed x1..x8 from x0, then r-type from those into x9..x15
        begin_test("independent");
        for (int k = 1; k <= 8; k++) begin
            send(make_rand_i(5'd0, REG_ADDR_W'(k)));
        end
        settle();
        for (int k = 0; k < 24; k++) begin
            ra = pick_reg(1, 8);
            rb = pick_reg(1, 8);
            send(make_rand_r(ra, rb, REG_ADDR_W'(9 + k % 7)));
        end
        settle();
        close_test();

        // each op reads the previous destination
        begin_test("raw");
        prev = 5'd1;
        for (int k = 0; k < 40; k++) begin
            r  = rnd();
            ra = pick_reg(1, 4);
            rc = pick_reg(1, 4);
            if (r[0]) begin
                send(make_rand_r(ra, prev, rc));
            end else begin
                send(make_rand_i(prev, rc));
            end
            prev = rc;
        end
        settle();
        close_test();

        // two writes to one register, then copy it out
        begin_test("waw");
        for (int k = 0; k < 8; k++) begin
            rc = pick_reg(1, 6);
            send(make_rand_i(5'd0, rc));
            send(make_rand_i(5'd0, rc));
            send(make_r(7'd0, 5'd0, rc, F3_OR, 5'd10));
        end
        settle();
        close_test();

        begin_test("dropped");
        for (int k = 0; k < 4; k++) begin
            ra = pick_reg(1, 6);
            rb = pick_reg(1, 6);
            rc = pick_reg(1, 6);
            send(illegal_word());
            // mul encoding sits outside the subset
            send(make_r(7'b0000001, ra, rb, F3_ADD, rc));
            send(make_rand_r(ra, rb, 5'd0));
            r = rnd();
            send(make_i(r[31:20], 5'd0, F3_OR, 5'd11));
            send(make_r(7'd0, 5'd0, 5'd0, F3_ADD, 5'd12));
        end
        settle();
        close_test();

        // mixed stream over x0..x6 with some garbage words
        begin_test("latency");
        for (int k = 0; k < 60; k++) begin
            r  = rnd();
            ra = pick_reg(0, 7);
            rb = pick_reg(0, 7);
            rc = pick_reg(0, 7);
            if (r % 10 == 0) begin
                send(illegal_word());
            end else if (r[4]) begin
                send(make_rand_r(ra, rb, rc));
            end else begin
                send(make_rand_i(rb, rc));
            end
        end
        settle();
        close_test();

        $display("tests run %0d, passed %0d, failed %0d, errors %0d",
                 tests_run, tests_run - tests_failed, tests_failed, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// ==== all.f ====
rtl/issue_pkg.sv
rtl/issue_bus_if.sv
rtl/reg_inuse.sv
rtl/reg_file.sv
rtl/decode_issue.sv
rtl/alu_pipe.sv
rtl/issue_pipeline_top.sv
verif/issue_pipeline_properties.sv
verif/issue_pipeline_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the issue pipeline testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f all.f --top-module issue_pipeline_tb \
    -o issue_pipeline_sim

status=0
./obj_dir/issue_pipeline_sim > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "sim failed" sim.log; then
    echo "run failed"
    exit 1
fi
echo "run finished"
